// File: design/rv_ctrl_pkg.sv
package rv_ctrl_pkg;

   localparam int XLEN_INSTR = 32;

   // Modified opcode map of this core
   localparam logic [6:0] OPC_OP          = 7'd51;
   localparam logic [6:0] OPC_OP_IMM      = 7'd19;
   localparam logic [6:0] OPC_LOAD        = 7'd3;
   localparam logic [6:0] OPC_STORE       = 7'd35;
   localparam logic [6:0] OPC_BRANCH_EQ   = 7'd99;
   localparam logic [6:0] OPC_BRANCH_JALR = 7'd103;  // BNE, BLT, BGE and JALR share it
   localparam logic [6:0] OPC_LUI         = 7'd55;

   localparam logic [2:0] F3_ADD_SUB = 3'd0;
   localparam logic [2:0] F3_SLT     = 3'd2;
   localparam logic [2:0] F3_LD      = 3'd3;
   localparam logic [2:0] F3_SD      = 3'd7;
   localparam logic [2:0] F3_BNE     = 3'd1;
   localparam logic [2:0] F3_BLT     = 3'd4;
   localparam logic [2:0] F3_BGE     = 3'd5;
   localparam logic [2:0] F3_JALR    = 3'd0;

   localparam logic [6:0] F7_ADD = 7'd0;
   localparam logic [6:0] F7_SUB = 7'd32;

   typedef enum logic [3:0] {
      CLS_ADD,
      CLS_SUB,
      CLS_SLT,
      CLS_ADDI,
      CLS_SLTI,
      CLS_LD,
      CLS_SD,
      CLS_BEQ,
      CLS_BNE,
      CLS_BLT,
      CLS_BGE,
      CLS_JALR,
      CLS_LUI,
      CLS_ILLEGAL
   } instr_class_t;

   typedef enum logic [4:0] {
      ST_RESET,
      ST_FETCH,
      ST_PC_INC,
      ST_DECODE,
      ST_EXEC_ALU,
      ST_SLT_ARM,
      ST_SLT_PICK,
      ST_WRITEBACK,
      ST_MEM_ADDR,
      ST_LD_WAIT,
      ST_LD_MDR,
      ST_LD_WB,
      ST_SD_WRITE,
      ST_SD_DONE,
      ST_BR_TARGET,
      ST_BR_RESOLVE,
      ST_JALR_LINK,
      ST_JALR_WB,
      ST_JALR_JUMP,
      ST_LUI
   } step_t;

   typedef enum logic [2:0] {
      ALU_PASS = 3'd0,
      ALU_ADD  = 3'd1,
      ALU_SUB  = 3'd2
   } alu_op_t;

   typedef enum logic [1:0] {
      SRCA_PC    = 2'd0,
      SRCA_REG_A = 2'd1,
      SRCA_ZERO  = 2'd2,
      SRCA_ONE   = 2'd3
   } alu_a_sel_t;

   typedef enum logic [2:0] {
      SRCB_REG_B       = 3'd0,
      SRCB_FOUR        = 3'd1,
      SRCB_IMM         = 3'd2,
      SRCB_IMM_SHIFTED = 3'd3,  // Branch offset, already doubled
      SRCB_ZERO        = 3'd4
   } alu_b_sel_t;

   typedef struct packed {
      logic       datapath_reset;
      logic       ir_load;
      logic       a_load;
      logic       b_load;
      logic       alu_out_load;
      logic       mdr_load;
      logic       reg_write;
      logic       wb_from_mdr;      // Register file data from MDR instead of ALU out
      logic       mem_write;
      logic       pc_write;
      logic       pc_from_alu_out;  // PC loads ALU out instead of ALU result
      alu_a_sel_t alu_src_a;
      alu_b_sel_t alu_src_b;
      alu_op_t    alu_op;
   } ctrl_word_t;

   localparam ctrl_word_t CTRL_IDLE = '{
      datapath_reset:  1'b0,
      ir_load:         1'b0,
      a_load:          1'b0,
      b_load:          1'b0,
      alu_out_load:    1'b0,
      mdr_load:        1'b0,
      reg_write:       1'b0,
      wb_from_mdr:     1'b0,
      mem_write:       1'b0,
      pc_write:        1'b0,
      pc_from_alu_out: 1'b0,
      alu_src_a:       SRCA_PC,
      alu_src_b:       SRCB_REG_B,
      alu_op:          ALU_PASS
   };

endpackage

// File: design/rv_instr_decoder.sv
`timescale 1ns/1ps

module rv_instr_decoder (
   input  logic [rv_ctrl_pkg::XLEN_INSTR-1:0] instr,
   output rv_ctrl_pkg::instr_class_t          instr_class
);

   logic [6:0] opcode;
   logic [2:0] funct3;
   logic [6:0] funct7;

   assign opcode = instr[6:0];
   assign funct3 = instr[14:12];
   assign funct7 = instr[31:25];

   always_comb
   begin
      instr_class = rv_ctrl_pkg::CLS_ILLEGAL;
      case (opcode)
         rv_ctrl_pkg::OPC_OP:
         begin
            if (funct3 == rv_ctrl_pkg::F3_ADD_SUB)
            begin
               if (funct7 == rv_ctrl_pkg::F7_ADD)
                  instr_class = rv_ctrl_pkg::CLS_ADD;
               else if (funct7 == rv_ctrl_pkg::F7_SUB)
                  instr_class = rv_ctrl_pkg::CLS_SUB;
            end
            else if (funct3 == rv_ctrl_pkg::F3_SLT && funct7 == rv_ctrl_pkg::F7_ADD)
               instr_class = rv_ctrl_pkg::CLS_SLT;
         end
         rv_ctrl_pkg::OPC_OP_IMM:
         begin
            if (funct3 == rv_ctrl_pkg::F3_ADD_SUB)
               instr_class = rv_ctrl_pkg::CLS_ADDI;
            else if (funct3 == rv_ctrl_pkg::F3_SLT)
               instr_class = rv_ctrl_pkg::CLS_SLTI;
         end
         rv_ctrl_pkg::OPC_LOAD:
         begin
            if (funct3 == rv_ctrl_pkg::F3_LD)  // Only the doubleword load
               instr_class = rv_ctrl_pkg::CLS_LD;
         end
         rv_ctrl_pkg::OPC_STORE:
         begin
            if (funct3 == rv_ctrl_pkg::F3_SD)
               instr_class = rv_ctrl_pkg::CLS_SD;
         end
         rv_ctrl_pkg::OPC_BRANCH_EQ:
         begin
            instr_class = rv_ctrl_pkg::CLS_BEQ;  // Opcode alone selects BEQ
         end
         rv_ctrl_pkg::OPC_BRANCH_JALR:
         begin
            case (funct3)
               rv_ctrl_pkg::F3_JALR: instr_class = rv_ctrl_pkg::CLS_JALR;
               rv_ctrl_pkg::F3_BNE:  instr_class = rv_ctrl_pkg::CLS_BNE;
               rv_ctrl_pkg::F3_BLT:  instr_class = rv_ctrl_pkg::CLS_BLT;
               rv_ctrl_pkg::F3_BGE:  instr_class = rv_ctrl_pkg::CLS_BGE;
               default:              instr_class = rv_ctrl_pkg::CLS_ILLEGAL;
            endcase
         end
         rv_ctrl_pkg::OPC_LUI:
         begin
            instr_class = rv_ctrl_pkg::CLS_LUI;
         end
         default:
         begin
            instr_class = rv_ctrl_pkg::CLS_ILLEGAL;
         end
      endcase
   end

endmodule

// File: design/rv_step_sequencer.sv
`timescale 1ns/1ps

module rv_step_sequencer (
   input  logic                      CLK,
   input  logic                      RESET,
   input  rv_ctrl_pkg::instr_class_t instr_class,
   input  logic                      eq,
   input  logic                      lt,
   output rv_ctrl_pkg::step_t        step,
   output logic                      br_taken
);

   rv_ctrl_pkg::step_t step_next;

   // Condition outcome, also used to pick the SLT result
   always_comb
   begin
      case (instr_class)
         rv_ctrl_pkg::CLS_BEQ:  br_taken = eq;
         rv_ctrl_pkg::CLS_BNE:  br_taken = !eq;
         rv_ctrl_pkg::CLS_BLT:  br_taken = lt;
         rv_ctrl_pkg::CLS_BGE:  br_taken = !lt;
         rv_ctrl_pkg::CLS_SLT:  br_taken = lt;
         rv_ctrl_pkg::CLS_SLTI: br_taken = lt;
         default:               br_taken = 1'b0;
      endcase
   end

   always_ff @(posedge CLK, posedge RESET)
   begin
      if (RESET)
         step <= rv_ctrl_pkg::ST_RESET;
      else
         step <= step_next;
   end

   always_comb
   begin
      step_next = rv_ctrl_pkg::ST_RESET;
      case (step)
         rv_ctrl_pkg::ST_RESET:     step_next = rv_ctrl_pkg::ST_FETCH;
         rv_ctrl_pkg::ST_FETCH:     step_next = rv_ctrl_pkg::ST_PC_INC;
         rv_ctrl_pkg::ST_PC_INC:    step_next = rv_ctrl_pkg::ST_DECODE;
         rv_ctrl_pkg::ST_DECODE:
         begin
            case (instr_class)
               rv_ctrl_pkg::CLS_ADD,
               rv_ctrl_pkg::CLS_SUB,
               rv_ctrl_pkg::CLS_ADDI: step_next = rv_ctrl_pkg::ST_EXEC_ALU;
               rv_ctrl_pkg::CLS_SLT,
               rv_ctrl_pkg::CLS_SLTI: step_next = rv_ctrl_pkg::ST_SLT_ARM;
               rv_ctrl_pkg::CLS_LD,
               rv_ctrl_pkg::CLS_SD:   step_next = rv_ctrl_pkg::ST_MEM_ADDR;
               rv_ctrl_pkg::CLS_BEQ,
               rv_ctrl_pkg::CLS_BNE,
               rv_ctrl_pkg::CLS_BLT,
               rv_ctrl_pkg::CLS_BGE:  step_next = rv_ctrl_pkg::ST_BR_TARGET;
               rv_ctrl_pkg::CLS_JALR: step_next = rv_ctrl_pkg::ST_JALR_LINK;
               rv_ctrl_pkg::CLS_LUI:  step_next = rv_ctrl_pkg::ST_LUI;
               default:               step_next = rv_ctrl_pkg::ST_RESET;  // Illegal
            endcase
         end
         rv_ctrl_pkg::ST_EXEC_ALU:  step_next = rv_ctrl_pkg::ST_WRITEBACK;
         rv_ctrl_pkg::ST_LUI:       step_next = rv_ctrl_pkg::ST_WRITEBACK;
         rv_ctrl_pkg::ST_SLT_ARM:   step_next = rv_ctrl_pkg::ST_SLT_PICK;
         rv_ctrl_pkg::ST_SLT_PICK:  step_next = rv_ctrl_pkg::ST_WRITEBACK;
         rv_ctrl_pkg::ST_WRITEBACK: step_next = rv_ctrl_pkg::ST_FETCH;
         rv_ctrl_pkg::ST_MEM_ADDR:
         begin
            if (instr_class == rv_ctrl_pkg::CLS_LD)
               step_next = rv_ctrl_pkg::ST_LD_WAIT;
            else if (instr_class == rv_ctrl_pkg::CLS_SD)
               step_next = rv_ctrl_pkg::ST_SD_WRITE;
            else
               step_next = rv_ctrl_pkg::ST_RESET;  // Instruction changed under us
         end
         rv_ctrl_pkg::ST_LD_WAIT:    step_next = rv_ctrl_pkg::ST_LD_MDR;  // Memory read latency
         rv_ctrl_pkg::ST_LD_MDR:     step_next = rv_ctrl_pkg::ST_LD_WB;
         rv_ctrl_pkg::ST_LD_WB:      step_next = rv_ctrl_pkg::ST_FETCH;
         rv_ctrl_pkg::ST_SD_WRITE:   step_next = rv_ctrl_pkg::ST_SD_DONE;
         rv_ctrl_pkg::ST_SD_DONE:    step_next = rv_ctrl_pkg::ST_FETCH;
         rv_ctrl_pkg::ST_BR_TARGET:  step_next = rv_ctrl_pkg::ST_BR_RESOLVE;
         rv_ctrl_pkg::ST_BR_RESOLVE: step_next = rv_ctrl_pkg::ST_FETCH;
         rv_ctrl_pkg::ST_JALR_LINK:  step_next = rv_ctrl_pkg::ST_JALR_WB;
         rv_ctrl_pkg::ST_JALR_WB:    step_next = rv_ctrl_pkg::ST_JALR_JUMP;
         rv_ctrl_pkg::ST_JALR_JUMP:  step_next = rv_ctrl_pkg::ST_FETCH;
         default:                    step_next = rv_ctrl_pkg::ST_RESET;
      endcase
   end

   a_step_known: assert property (
      @(posedge CLK) disable iff (RESET)
      !$isunknown(step)
   ) else $error("Step register went unknown");

   // Every instruction ends, legal or not, in a fresh fetch
   a_fetch_after_last: assert property (
      @(posedge CLK) disable iff (RESET)
      step inside {rv_ctrl_pkg::ST_WRITEBACK, rv_ctrl_pkg::ST_LD_WB,
                   rv_ctrl_pkg::ST_SD_DONE, rv_ctrl_pkg::ST_BR_RESOLVE,
                   rv_ctrl_pkg::ST_JALR_JUMP, rv_ctrl_pkg::ST_RESET}
      |=> step == rv_ctrl_pkg::ST_FETCH
   ) else $error("Final step not followed by fetch");

endmodule

// File: design/rv_control_rom.sv
`timescale 1ns/1ps

module rv_control_rom (
   input  rv_ctrl_pkg::step_t        step,
   input  rv_ctrl_pkg::instr_class_t instr_class,
   input  logic                      br_taken,
   output rv_ctrl_pkg::ctrl_word_t   ctrl
);

   always_comb
   begin
      ctrl = rv_ctrl_pkg::CTRL_IDLE;
      case (step)
         rv_ctrl_pkg::ST_RESET:
         begin
            ctrl.datapath_reset = 1'b1;
         end
         rv_ctrl_pkg::ST_FETCH:
         begin
            ctrl.ir_load   = 1'b1;
            ctrl.reg_write = 1'b1;  // Register file strobed on every fetch
         end
         rv_ctrl_pkg::ST_PC_INC:
         begin
            ctrl.ir_load   = 1'b1;
            ctrl.pc_write  = 1'b1;
            ctrl.alu_src_a = rv_ctrl_pkg::SRCA_PC;
            ctrl.alu_src_b = rv_ctrl_pkg::SRCB_FOUR;  // PC + 4
            ctrl.alu_op    = rv_ctrl_pkg::ALU_ADD;
         end
         rv_ctrl_pkg::ST_DECODE:
         begin
            ctrl.a_load = 1'b1;
            ctrl.b_load = 1'b1;
         end
         rv_ctrl_pkg::ST_EXEC_ALU:
         begin
            ctrl.alu_out_load = 1'b1;
            ctrl.alu_src_a    = rv_ctrl_pkg::SRCA_REG_A;
            if (instr_class == rv_ctrl_pkg::CLS_ADDI)
               ctrl.alu_src_b = rv_ctrl_pkg::SRCB_IMM;
            else
               ctrl.alu_src_b = rv_ctrl_pkg::SRCB_REG_B;
            if (instr_class == rv_ctrl_pkg::CLS_SUB)
               ctrl.alu_op = rv_ctrl_pkg::ALU_SUB;
            else
               ctrl.alu_op = rv_ctrl_pkg::ALU_ADD;
         end
         rv_ctrl_pkg::ST_SLT_PICK:
         begin
            // Result is 1 + 0 or 0 + 0 depending on the compare
            ctrl.alu_out_load = 1'b1;
            ctrl.alu_src_a    = br_taken ? rv_ctrl_pkg::SRCA_ONE : rv_ctrl_pkg::SRCA_ZERO;
            ctrl.alu_src_b    = rv_ctrl_pkg::SRCB_ZERO;
            ctrl.alu_op       = rv_ctrl_pkg::ALU_ADD;
         end
         rv_ctrl_pkg::ST_LUI:
         begin
            ctrl.alu_out_load = 1'b1;
            ctrl.alu_src_a    = rv_ctrl_pkg::SRCA_ZERO;
            ctrl.alu_src_b    = rv_ctrl_pkg::SRCB_IMM;
            ctrl.alu_op       = rv_ctrl_pkg::ALU_ADD;
         end
         rv_ctrl_pkg::ST_MEM_ADDR:
         begin
            ctrl.alu_out_load = 1'b1;  // Effective address rs1 + imm
            ctrl.alu_src_a    = rv_ctrl_pkg::SRCA_REG_A;
            ctrl.alu_src_b    = rv_ctrl_pkg::SRCB_IMM;
            ctrl.alu_op       = rv_ctrl_pkg::ALU_ADD;
         end
         rv_ctrl_pkg::ST_LD_MDR:
         begin
            ctrl.mdr_load = 1'b1;
         end
         rv_ctrl_pkg::ST_LD_WB:
         begin
            ctrl.reg_write   = 1'b1;
            ctrl.wb_from_mdr = 1'b1;
         end
         rv_ctrl_pkg::ST_SD_WRITE:
         begin
            ctrl.mem_write = 1'b1;
         end
         rv_ctrl_pkg::ST_BR_TARGET:
         begin
            ctrl.alu_out_load = 1'b1;
            ctrl.alu_src_a    = rv_ctrl_pkg::SRCA_PC;
            ctrl.alu_src_b    = rv_ctrl_pkg::SRCB_IMM_SHIFTED;
            ctrl.alu_op       = rv_ctrl_pkg::ALU_ADD;
         end
         rv_ctrl_pkg::ST_BR_RESOLVE:
         begin
            ctrl.pc_write        = br_taken;
            ctrl.pc_from_alu_out = br_taken;  // Target saved in BR_TARGET
         end
         rv_ctrl_pkg::ST_JALR_LINK:
         begin
            ctrl.alu_out_load = 1'b1;  // Return address, PC already advanced
            ctrl.alu_src_a    = rv_ctrl_pkg::SRCA_PC;
            ctrl.alu_src_b    = rv_ctrl_pkg::SRCB_ZERO;
            ctrl.alu_op       = rv_ctrl_pkg::ALU_ADD;
         end
         rv_ctrl_pkg::ST_JALR_WB:
         begin
            ctrl.reg_write = 1'b1;
         end
         rv_ctrl_pkg::ST_JALR_JUMP:
         begin
            ctrl.pc_write  = 1'b1;
            ctrl.alu_src_a = rv_ctrl_pkg::SRCA_REG_A;
            ctrl.alu_src_b = rv_ctrl_pkg::SRCB_IMM;
            ctrl.alu_op    = rv_ctrl_pkg::ALU_ADD;
         end
         rv_ctrl_pkg::ST_WRITEBACK:
         begin
            ctrl.reg_write = 1'b1;
         end
         default:
         begin
            ctrl = rv_ctrl_pkg::CTRL_IDLE;  // ARM, LD_WAIT and SD_DONE hold still
         end
      endcase
   end

   // Register file and data memory are never written in the same step
   a_no_dual_write: assert final (!(ctrl.mem_write && ctrl.reg_write))
      else $error("mem_write and reg_write both high in step %s", step.name());

   a_no_pc_in_reset: assert final (!(ctrl.datapath_reset && ctrl.pc_write))
      else $error("pc_write during datapath reset");

endmodule

// File: design/rv_control_unit.sv
`timescale 1ns/1ps

module rv_control_unit (
   input  logic                              CLK,
   input  logic                              RESET,
   input  logic [rv_ctrl_pkg::XLEN_INSTR-1:0] instr,  // Held from fetch to next fetch
   input  logic                              eq,
   input  logic                              lt,
   output rv_ctrl_pkg::ctrl_word_t           ctrl
);

   rv_ctrl_pkg::instr_class_t instr_class;
   rv_ctrl_pkg::step_t        step;
   logic                      br_taken;

   rv_instr_decoder u_decoder (
      .instr       (instr),
      .instr_class (instr_class)
   );

   rv_step_sequencer u_sequencer (
      .CLK         (CLK),
      .RESET       (RESET),
      .instr_class (instr_class),
      .eq          (eq),
      .lt          (lt),
      .step        (step),
      .br_taken    (br_taken)
   );

   // Control word straight from the step register, no output stage
   rv_control_rom u_rom (
      .step        (step),
      .instr_class (instr_class),
      .br_taken    (br_taken),
      .ctrl        (ctrl)
   );

endmodule

// File: include/tb_check.svh
`ifndef TB_CHECK_SVH
`define TB_CHECK_SVH

int unsigned fetch_timeout_cycles = 40;

// Single exit point for every failing run
task automatic report_failure();
   $display("SIMULATION FAILED");
   $fatal(1);
endtask

task automatic check_value(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
   if (expected !== actual)
   begin
      $display("ERROR %s: expected %0h, actual %0h", name, expected, actual);
      report_failure();
   end
endtask

// Fetch word is ir_load without pc_write
function automatic bit is_fetch_word(input rv_ctrl_pkg::ctrl_word_t w);
   return w.ir_load && !w.pc_write && !w.datapath_reset;
endfunction

// Call at a falling edge; returns at the falling edge of a fetch cycle
task automatic wait_for_fetch(input string name);
   int unsigned cycles;
   cycles = 0;
   while (!is_fetch_word(ctrl))
   begin
      if (cycles >= fetch_timeout_cycles)
      begin
         $display("%s: no instruction fetch seen within %0d cycles", name,
                  fetch_timeout_cycles);
         report_failure();
      end
      @(negedge CLK);
      cycles++;
   end
endtask

`endif

// File: verification/tb_rv_control_unit.sv
`timescale 1ns/1ps

module tb_rv_control_unit;

   logic                     CLK;
   logic                     RESET;
   logic [31:0]              instr;
   logic                     eq;
   logic                     lt;
   rv_ctrl_pkg::ctrl_word_t  ctrl;
   rv_ctrl_pkg::ctrl_word_t  words [1:8];  // Control word per instruction cycle
   integer                   seed;

   `include "tb_check.svh"

   rv_control_unit DUT (
      .CLK   (CLK),
      .RESET (RESET),
      .instr (instr),
      .eq    (eq),
      .lt    (lt),
      .ctrl  (ctrl)
   );

   always #4 CLK = ~CLK;

   function automatic logic [31:0] encode(input logic [6:0] f7, input logic [2:0] f3,
                                          input logic [6:0] opc);
      return {f7, 10'h0a5, f3, 5'd3, opc};  // Register fields are arbitrary
   endfunction

   // Runs one instruction from its fetch, ends at the fetch that follows
   task automatic run_instr(input string name, input logic [31:0] word,
                            input logic eq_v, input logic lt_v, input int n);
      wait_for_fetch(name);
      words[1] = ctrl;
      @(posedge CLK);
      #1;
      instr = word;
      eq    = eq_v;
      lt    = lt_v;
      for (int c = 2; c <= n; c++)
      begin
         @(negedge CLK);
         words[c] = ctrl;
      end
      @(negedge CLK);
      check_value({name, " next fetch"}, 1, is_fetch_word(ctrl));
      check_value({name, " pc_inc pc_write"}, 1, words[2].pc_write);
      check_value({name, " decode a_load"}, 1, words[3].a_load);
      check_value({name, " decode b_load"}, 1, words[3].b_load);
   endtask

   task automatic check_reg_write(input string name, input int n, input int wb_cycle);
      for (int c = 1; c <= n; c++)
         check_value($sformatf("%s reg_write c%0d", name, c),
                     (c == 1 || c == wb_cycle), words[c].reg_write);
   endtask

   task automatic test_reset();
      @(negedge CLK);
      check_value("reset datapath_reset", 1, ctrl.datapath_reset);
      check_value("reset reg_write", 0, ctrl.reg_write);
      check_value("reset mem_write", 0, ctrl.mem_write);
      check_value("reset pc_write", 0, ctrl.pc_write);
      @(posedge CLK);
      #1;
      RESET = 1'b0;
      @(negedge CLK);
      check_value("reset step after release", 1, ctrl.datapath_reset);
      @(negedge CLK);
      check_value("first fetch ir_load", 1, ctrl.ir_load);
      check_value("first fetch reg_write", 1, ctrl.reg_write);
   endtask

   task automatic alu_case(input string name, input logic [31:0] word,
                           input logic [1:0] src_a, input logic [2:0] src_b,
                           input logic [2:0] op);
      run_instr(name, word, 1'b0, 1'b0, 5);
      check_reg_write(name, 5, 5);
      check_value({name, " alu_out_load"}, 1, words[4].alu_out_load);
      check_value({name, " src_a"}, src_a, words[4].alu_src_a);
      check_value({name, " src_b"}, src_b, words[4].alu_src_b);
      check_value({name, " alu_op"}, op, words[4].alu_op);
   endtask

   task automatic test_alu();
      alu_case("ADD", encode(7'd0, 3'd0, 7'd51), 2'd1, 3'd0, 3'd1);
      alu_case("SUB", encode(7'd32, 3'd0, 7'd51), 2'd1, 3'd0, 3'd2);
      alu_case("ADDI", encode(7'h15, 3'd0, 7'd19), 2'd1, 3'd2, 3'd1);
      alu_case("LUI", encode(7'h2a, 3'd6, 7'd55), 2'd2, 3'd2, 3'd1);
   endtask

   task automatic test_slt();
      logic [31:0] words_in [2];
      string       name;
      words_in[0] = encode(7'd0, 3'd2, 7'd51);
      words_in[1] = encode(7'h11, 3'd2, 7'd19);
      for (int i = 0; i < 2; i++)
         for (int l = 0; l < 2; l++)
         begin
            if (i == 0)
               name = "SLT";
            else
               name = "SLTI";
            run_instr(name, words_in[i], 1'b0, l[0], 6);
            check_reg_write(name, 6, 6);
            check_value({name, " pick src_a"}, l ? 2'd3 : 2'd2, words[5].alu_src_a);
            check_value({name, " pick src_b"}, 3'd4, words[5].alu_src_b);
            check_value({name, " alu_out_load"}, 1, words[5].alu_out_load);
         end
   endtask

   task automatic test_load_store();
      run_instr("LD", encode(7'h01, 3'd3, 7'd3), 1'b0, 1'b0, 7);
      check_reg_write("LD", 7, 7);
      for (int c = 1; c <= 7; c++)
         check_value($sformatf("LD mdr_load c%0d", c), c == 6, words[c].mdr_load);
      check_value("LD wb_from_mdr", 1, words[7].wb_from_mdr);
      run_instr("SD", encode(7'h03, 3'd7, 7'd35), 1'b0, 1'b0, 6);
      check_reg_write("SD", 6, 0);
      for (int c = 1; c <= 6; c++)
         check_value($sformatf("SD mem_write c%0d", c), c == 5, words[c].mem_write);
   endtask

   task automatic test_branches();
      logic  e;
      logic  l;
      logic  taken;
      string name;
      for (int k = 0; k < 16; k++)
      begin
         e = $random(seed) & 1;
         l = $random(seed) & 1;
         case (k % 4)
            0: taken = e;
            1: taken = !e;
            2: taken = l;
            default: taken = !l;
         endcase
         case (k % 4)
            0: name = "BEQ";
            1: name = "BNE";
            2: name = "BLT";
            default: name = "BGE";
         endcase
         case (k % 4)
            0: run_instr(name, encode(7'h05, 3'd0, 7'd99), e, l, 5);
            1: run_instr(name, encode(7'h05, 3'd1, 7'd103), e, l, 5);
            2: run_instr(name, encode(7'h05, 3'd4, 7'd103), e, l, 5);
            default: run_instr(name, encode(7'h05, 3'd5, 7'd103), e, l, 5);
         endcase
         check_value({name, " pc_write"}, taken, words[5].pc_write);
         check_value({name, " pc_from_alu_out"}, taken, words[5].pc_from_alu_out);
         check_value({name, " target src_b"}, 3'd3, words[4].alu_src_b);
         check_reg_write(name, 5, 0);
      end
   endtask

   task automatic test_jalr_illegal();
      run_instr("JALR", encode(7'h07, 3'd0, 7'd103), 1'b0, 1'b0, 6);
      check_reg_write("JALR", 6, 5);
      check_value("JALR pc_write c5", 0, words[5].pc_write);
      check_value("JALR pc_write c6", 1, words[6].pc_write);
      check_value("JALR jump src_a", 2'd1, words[6].alu_src_a);
      run_instr("ILLEGAL", encode(7'd0, 3'd0, 7'h7f), 1'b0, 1'b0, 4);
      check_value("ILLEGAL datapath_reset", 1, words[4].datapath_reset);
      check_value("ILLEGAL pc_write", 0, words[4].pc_write);
   endtask

   initial
   begin
      CLK   = 1'b0;
      RESET = 1'b1;
      instr = 32'h0;
      eq    = 1'b0;
      lt    = 1'b0;
      seed  = 32'h9ef3beee;
      repeat (8) @(posedge CLK);
      test_reset();
      test_alu();
      test_slt();
      test_load_store();
      test_branches();
      test_jalr_illegal();
      $display("SIMULATION PASSED");
      $finish;
   end

endmodule

// File: sim.f
+incdir+include
design/rv_ctrl_pkg.sv
design/rv_instr_decoder.sv
design/rv_step_sequencer.sv
design/rv_control_rom.sv
design/rv_control_unit.sv
verification/tb_rv_control_unit.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_rv_control_unit
RTL_TOP   ?= rv_control_unit
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
		echo "$$out" | grep -q "SIMULATION PASSED"

clean:
	rm -rf $(OBJ_DIR)
